/* Bender.yml */
package:
  name: spu

sources:
  - rtl/spu_pkg.sv
  - rtl/string_mem.sv
  - rtl/string_scanner.sv
  - rtl/str_combiner.sv
  - rtl/spu_top.sv
  - target: test
    files:
      - verif/spu_tb.sv

/* project.f */
rtl/spu_pkg.sv
rtl/string_mem.sv
rtl/string_scanner.sv
rtl/str_combiner.sv
rtl/spu_top.sv
verif/spu_tb.sv

/* rtl/spu_pkg.sv */
package spu_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Bytes per memory word
	localparam int WORD_BYTES = 16;
	localparam int DATA_W = 128;

	// Special register file address and result width
	localparam int SREG_AW = 4;
	localparam int RES_W = 32;

	////////////////////////////////////////////////////////////
	// Op codes
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_STRLEN = 2'd0,
		OP_STRCMP = 2'd1,
		OP_COUNT  = 2'd2
	} spu_op_e;

	////////////////////////////////////////////////////////////
	// Shared structs
	////////////////////////////////////////////////////////////

	// Command captured at start, string locations are byte addresses
	typedef struct packed {
		spu_op_e     op;
		logic [3:0]  dest;
		logic [7:0]  delim;
		logic [31:0] loc_a;
		logic [31:0] loc_b;
	} spu_cmd_t;

	// One byte of a string stream
	typedef struct packed {
		logic        valid;
		logic        last;
		logic [7:0]  ch;
		logic [15:0] index;
	} char_beat_t;

	// Word write from outside, addr is a word address
	typedef struct packed {
		logic              we;
		logic [15:0]       addr;
		logic [DATA_W-1:0] data;
	} mem_wr_t;

	typedef struct packed {
		logic               we;
		logic [SREG_AW-1:0] addr;
		logic [RES_W-1:0]   data;
	} sreg_wr_t;

endpackage

/* rtl/spu_top.sv */
module spu_top #(
	parameter int ADDR_W  = 10,
	parameter int MAX_LEN = 64
) (
	input  logic              clk,
	input  logic              i_arst_n,
	input  logic              i_start,
	input  spu_pkg::spu_cmd_t i_cmd,
	input  spu_pkg::mem_wr_t  i_mem_wr,
	output spu_pkg::sreg_wr_t o_sreg,
	output logic              o_done,
	output logic              o_busy
);
	import spu_pkg::*;

	logic                                  scan_start;
	logic                                  stop;
	logic [31:0]                           base_a;
	logic [31:0]                           base_b;
	logic [ADDR_W-$clog2(WORD_BYTES)-1:0]  raddr_a;
	logic [ADDR_W-$clog2(WORD_BYTES)-1:0]  raddr_b;
	logic [DATA_W-1:0]                     rdata_a;
	logic [DATA_W-1:0]                     rdata_b;
	char_beat_t                            beat_a;
	char_beat_t                            beat_b;

	string_mem #(
		.ADDR_W(ADDR_W)
	) mem0 (
		.clk(clk),
		.i_wr(i_mem_wr),
		.i_raddr_a(raddr_a),
		.i_raddr_b(raddr_b),
		.o_rdata_a(rdata_a),
		.o_rdata_b(rdata_b)
	);

	// String A on read port a, string B on read port b
	string_scanner #(
		.ADDR_W(ADDR_W),
		.MAX_LEN(MAX_LEN)
	) scan_a (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_start(scan_start),
		.i_stop(stop),
		.i_base(base_a[ADDR_W-1:0]),
		.o_raddr(raddr_a),
		.i_rdata(rdata_a),
		.o_beat(beat_a)
	);

	string_scanner #(
		.ADDR_W(ADDR_W),
		.MAX_LEN(MAX_LEN)
	) scan_b (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_start(scan_start),
		.i_stop(stop),
		.i_base(base_b[ADDR_W-1:0]),
		.o_raddr(raddr_b),
		.i_rdata(rdata_b),
		.o_beat(beat_b)
	);

	str_combiner #(
		.MAX_LEN(MAX_LEN)
	) comb0 (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_start(i_start),
		.i_cmd(i_cmd),
		.o_scan_start(scan_start),
		.o_base_a(base_a),
		.o_base_b(base_b),
		.o_stop(stop),
		.i_beat_a(beat_a),
		.i_beat_b(beat_b),
		.o_sreg(o_sreg),
		.o_done(o_done),
		.o_busy(o_busy)
	);

endmodule

/* rtl/str_combiner.sv */
module str_combiner #(
	parameter int MAX_LEN = 64
) (
	input  logic                clk,
	input  logic                i_arst_n,
	input  logic                i_start,
	input  spu_pkg::spu_cmd_t   i_cmd,
	output logic                o_scan_start,
	output logic [31:0]         o_base_a,
	output logic [31:0]         o_base_b,
	output logic                o_stop,
	input  spu_pkg::char_beat_t i_beat_a,
	input  spu_pkg::char_beat_t i_beat_b,
	output spu_pkg::sreg_wr_t   o_sreg,
	output logic                o_done,
	output logic                o_busy
);
	import spu_pkg::*;

	// Delimiter count never exceeds MAX_LEN
	localparam int CNT_W = $clog2(MAX_LEN + 1);

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		FINISH
	} state_e;

	state_e           state_q;
	spu_cmd_t         cmd_q;
	logic [CNT_W-1:0] cnt_q;
	logic [RES_W-1:0] res_q;

	logic             accept;
	logic             hit;
	logic             decide;
	logic [RES_W-1:0] res_d;

	////////////////////////////////////////////////////////////
	// Start and scanner control
	////////////////////////////////////////////////////////////

	// Starts while busy are dropped
	assign accept = i_start && (state_q == IDLE);

	assign o_scan_start = accept;
	assign o_base_a = i_cmd.loc_a;
	assign o_base_b = i_cmd.loc_b;
	assign o_stop = (state_q == FINISH);

	////////////////////////////////////////////////////////////
	// Deciding beat
	////////////////////////////////////////////////////////////

	assign hit = i_beat_a.valid && !i_beat_a.last && (i_beat_a.ch == cmd_q.delim);

	always_comb begin
		decide = 1'b0;
		res_d = '0;
		case (cmd_q.op)
			OP_STRLEN: begin
				if (i_beat_a.valid && i_beat_a.last) begin
					decide = 1'b1;
					res_d = RES_W'(i_beat_a.index);
				end
			end
			OP_COUNT: begin
				if (i_beat_a.valid && i_beat_a.last) begin
					decide = 1'b1;
					res_d = RES_W'(cnt_q);
				end
			end
			OP_STRCMP: begin
				if (i_beat_a.valid && i_beat_b.valid) begin
					// First difference, or only one string ends here
					if (i_beat_a.ch != i_beat_b.ch || i_beat_a.last != i_beat_b.last) begin
						decide = 1'b1;
						res_d = RES_W'(i_beat_a.index) + 1'b1;
					end else if (i_beat_a.last) begin
						decide = 1'b1;
					end
				end
			end
			default: begin
				decide = 1'b0;
			end
		endcase
		// Stale beats outside SCAN are ignored
		if (state_q != SCAN) begin
			decide = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= IDLE;
			cnt_q <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (accept) begin
						state_q <= SCAN;
						cnt_q <= '0;
					end
				end
				SCAN: begin
					if (decide) begin
						state_q <= FINISH;
					end else if (hit) begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				FINISH: begin
					state_q <= IDLE;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= i_cmd;
		end
		if (decide) begin
			res_q <= res_d;
		end
	end

	////////////////////////////////////////////////////////////
	// Result
	////////////////////////////////////////////////////////////

	assign o_busy = (state_q != IDLE);
	assign o_done = (state_q == FINISH);

	always_comb begin
		o_sreg.we = (state_q == FINISH);
		o_sreg.addr = cmd_q.dest;
		o_sreg.data = res_q;
	end

	// Stop leaves both scanners idle before the FSM returns to IDLE
	a_beats_busy: assert property (@(posedge clk) disable iff (!i_arst_n)
		(i_beat_a.valid || i_beat_b.valid) |-> o_busy);

	// Both scanners were started together so their beats line up
	a_cmp_aligned: assert property (@(posedge clk) disable iff (!i_arst_n)
		(state_q == SCAN && cmd_q.op == OP_STRCMP) |->
			(i_beat_a.valid == i_beat_b.valid) &&
			(!i_beat_a.valid || i_beat_a.index == i_beat_b.index));

endmodule

/* rtl/string_mem.sv */
module string_mem #(
	parameter int ADDR_W = 10
) (
	input  logic                                            clk,
	input  spu_pkg::mem_wr_t                                i_wr,
	input  logic [ADDR_W-$clog2(spu_pkg::WORD_BYTES)-1:0]   i_raddr_a,
	input  logic [ADDR_W-$clog2(spu_pkg::WORD_BYTES)-1:0]   i_raddr_b,
	output logic [spu_pkg::DATA_W-1:0]                      o_rdata_a,
	output logic [spu_pkg::DATA_W-1:0]                      o_rdata_b
);
	import spu_pkg::*;

	// Word address width and depth
	localparam int WA_W = ADDR_W - $clog2(WORD_BYTES);
	localparam int DEPTH = 2 ** WA_W;

	logic [DATA_W-1:0] mem [DEPTH];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	// Only the low word-address bits reach the array
	always_ff @(posedge clk) begin
		if (i_wr.we) begin
			mem[i_wr.addr[WA_W-1:0]] <= i_wr.data;
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////

	// Registered reads, a word written this cycle shows up from the next
	always_ff @(posedge clk) begin
		o_rdata_a <= mem[i_raddr_a];
	end

	always_ff @(posedge clk) begin
		o_rdata_b <= mem[i_raddr_b];
	end

endmodule

/* rtl/string_scanner.sv */
module string_scanner #(
	parameter int ADDR_W  = 10,
	parameter int MAX_LEN = 64
) (
	input  logic                                            clk,
	input  logic                                            i_arst_n,
	input  logic                                            i_start,
	input  logic                                            i_stop,
	input  logic [ADDR_W-1:0]                               i_base,
	output logic [ADDR_W-$clog2(spu_pkg::WORD_BYTES)-1:0]   o_raddr,
	input  logic [spu_pkg::DATA_W-1:0]                      i_rdata,
	output spu_pkg::char_beat_t                             o_beat
);
	import spu_pkg::*;

	localparam int OFF_W = $clog2(WORD_BYTES);
	localparam logic [15:0] IDX_MAX = 16'(MAX_LEN);

	// Address stage
	logic              a_valid;
	logic [ADDR_W-1:0] a_addr;
	logic [15:0]       a_idx;

	// Stage aligned with the returned word
	logic              p_valid;
	logic [OFF_W-1:0]  p_off;
	logic [15:0]       p_idx;

	logic [7:0]        cur_ch;
	logic              beat_last;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			a_valid <= 1'b0;
			p_valid <= 1'b0;
		end else if (i_start) begin
			a_valid <= 1'b1;
			p_valid <= 1'b0;
		end else if (i_stop || beat_last) begin
			// Drop any byte still in flight
			a_valid <= 1'b0;
			p_valid <= 1'b0;
		end else begin
			p_valid <= a_valid;
			// Nothing past MAX_LEN is ever needed
			if (a_valid && a_idx == IDX_MAX) begin
				a_valid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Address and index
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_start) begin
			a_addr <= i_base;
			a_idx <= '0;
		end else if (a_valid) begin
			a_addr <= a_addr + 1'b1;
			a_idx <= a_idx + 1'b1;
		end
		// One cycle of delay to match the read latency
		p_off <= a_addr[OFF_W-1:0];
		p_idx <= a_idx;
	end

	assign o_raddr = a_addr[ADDR_W-1:OFF_W];

	////////////////////////////////////////////////////////////
	// Byte pick and beat
	////////////////////////////////////////////////////////////

	// Byte 0 sits in the low lane of the word
	assign cur_ch = i_rdata[{p_off, 3'b000} +: 8];
	assign beat_last = p_valid && (cur_ch == 8'h00 || p_idx == IDX_MAX);

	always_comb begin
		o_beat.valid = p_valid;
		o_beat.last = beat_last;
		o_beat.ch = cur_ch;
		o_beat.index = p_idx;
	end

	a_idx_bound: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_beat.valid |-> o_beat.index <= IDX_MAX);

endmodule

/* verif/spu_tb.sv */
module spu_tb;
	import spu_pkg::*;

	localparam int ADDR_W = 10;
	localparam int MAX_LEN = 64;
	localparam int MEM_BYTES = 1 << ADDR_W;
	localparam int WORDS = MEM_BYTES / WORD_BYTES;
	localparam int N_CMDS = 16;
	// Every command reloads the whole memory before it starts
	localparam int LIMIT = N_CMDS * (MAX_LEN + 10 + WORDS + 2) + 20;

	logic       clk;
	logic       i_arst_n;
	logic       i_start;
	spu_cmd_t   i_cmd;
	mem_wr_t    i_mem_wr;
	sreg_wr_t   o_sreg;
	logic       o_done;
	logic       o_busy;

	logic [7:0]  mirror [MEM_BYTES];
	logic [15:0] lfsr_q;
	int          errors;
	int          checks;
	int          tests;
	int          cycles;

	spu_top #(
		.ADDR_W(ADDR_W),
		.MAX_LEN(MAX_LEN)
	) dut0 (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_start(i_start),
		.i_cmd(i_cmd),
		.i_mem_wr(i_mem_wr),
		.o_sreg(o_sreg),
		.o_done(o_done),
		.o_busy(o_busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", LIMIT);
		$display("Result: FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Random bits and memory image
	////////////////////////////////////////////////////////////

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int take_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r = (r << 1) | int'(lfsr_q[0]);
		end
		return r;
	endfunction

	function automatic logic [7:0] rand_char();
		return 8'h41 + 8'(take_bits(3));
	endfunction

	function automatic logic [7:0] byte_at(input int a);
		return mirror[a & (MEM_BYTES - 1)];
	endfunction

	task automatic put_str(input int loc, input int len, input bit term);
		for (int i = 0; i < len; i++) begin
			mirror[(loc + i) & (MEM_BYTES - 1)] = rand_char();
		end
		if (term) begin
			mirror[(loc + len) & (MEM_BYTES - 1)] = 8'h00;
		end
	endtask

	task automatic copy_bytes(input int src, input int dst, input int n);
		for (int i = 0; i < n; i++) begin
			mirror[(dst + i) & (MEM_BYTES - 1)] = byte_at(src + i);
		end
	endtask

	task automatic drive_slot();
		@(posedge clk);
		#1;
	endtask

	// Byte 0 of a word goes to the low lane
	task automatic load_mem();
		for (int w = 0; w < WORDS; w++) begin
			drive_slot();
			i_mem_wr.we = 1'b1;
			i_mem_wr.addr = 16'(w);
			for (int b = 0; b < WORD_BYTES; b++) begin
				i_mem_wr.data[b*8 +: 8] = mirror[w * WORD_BYTES + b];
			end
		end
		drive_slot();
		i_mem_wr.we = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic bit ends_at(input int loc, input int i);
		return (byte_at(loc + i) == 8'h00) || (i == MAX_LEN);
	endfunction

	function automatic int model_len(input int loc);
		int i;
		i = 0;
		while (!ends_at(loc, i)) begin
			i++;
		end
		return i;
	endfunction

	function automatic int model_count(input int loc, input logic [7:0] delim);
		int n;
		n = 0;
		for (int i = 0; i < model_len(loc); i++) begin
			if (byte_at(loc + i) == delim) begin
				n++;
			end
		end
		return n;
	endfunction

	function automatic int model_cmp(input int la, input int lb);
		for (int i = 0; i <= MAX_LEN; i++) begin
			if (byte_at(la + i) != byte_at(lb + i) || ends_at(la, i) != ends_at(lb, i)) begin
				return i + 1;
			end
			if (ends_at(la, i)) begin
				return 0;
			end
		end
		return 0;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks and test sequence
	////////////////////////////////////////////////////////////

	task automatic check_sreg(input sreg_wr_t got, input sreg_wr_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got we=%0b addr=%0d data=%0d, exp we=%0b addr=%0d data=%0d",
				$time, what, got.we, got.addr, got.data, exp.we, exp.addr, exp.data);
		end
	endtask

	task automatic check_busy(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s busy is %0b, expected %0b", $time, what, got, exp);
		end
	endtask

	function automatic spu_cmd_t mk_cmd(input spu_op_e op, input int la, input int lb,
			input logic [7:0] delim);
		spu_cmd_t c;
		c.op = op;
		c.dest = 4'(take_bits(4));
		c.delim = delim;
		c.loc_a = 32'(la);
		c.loc_b = 32'(lb);
		return c;
	endfunction

	task automatic run_test(input string name, input spu_cmd_t cmd, input bit extra,
			input spu_cmd_t other);
		sreg_wr_t exp;
		int errs_before;
		int cyc;
		bit got;
		errs_before = errors;
		load_mem();
		exp.we = 1'b1;
		exp.addr = cmd.dest;
		case (cmd.op)
			OP_STRLEN: exp.data = RES_W'(model_len(cmd.loc_a));
			OP_COUNT: exp.data = RES_W'(model_count(cmd.loc_a, cmd.delim));
			default: exp.data = RES_W'(model_cmp(cmd.loc_a, cmd.loc_b));
		endcase
		drive_slot();
		i_start = 1'b1;
		i_cmd = cmd;
		drive_slot();
		i_start = 1'b0;
		cyc = 0;
		got = 1'b0;
		while (!got) begin
			@(negedge clk);
			check_busy(o_busy, 1'b1, name);
			if (o_done) begin
				check_sreg(o_sreg, exp, name);
				got = 1'b1;
			end
			drive_slot();
			// A second start lands while the first command is still in SCAN
			i_start = extra && !got && cyc == 0;
			i_cmd = extra ? other : cmd;
			cyc++;
		end
		i_start = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_busy(o_busy, 1'b0, name);
			if (o_done || o_sreg.we) begin
				errors++;
				$display("FAIL %0t: %s extra result after done", $time, name);
			end
		end
		tests++;
		$display("test %s %s", name, (errors == errs_before) ? "ok" : "had errors");
	endtask

	initial begin
		int la;
		int lb;
		int len;
		int k;
		logic [7:0] dl;
		spu_cmd_t c2;
		lfsr_q = 16'd38;
		errors = 0;
		checks = 0;
		tests = 0;
		i_arst_n = 1'b0;
		i_start = 1'b0;
		i_cmd = '0;
		i_mem_wr = '0;
		// Nonzero background so only written NULs end a string
		for (int a = 0; a < MEM_BYTES; a++) begin
			mirror[a] = {1'b1, 7'(a ^ (a >> 7))};
		end
		repeat (3) @(posedge clk);
		#1;
		i_arst_n = 1'b1;
		@(negedge clk);
		check_busy(o_busy, 1'b0, "reset");
		check_busy(o_done, 1'b0, "reset done");
		check_busy(o_sreg.we, 1'b0, "reset we");
		put_str(40, 0, 1'b1);
		run_test("strlen_empty", mk_cmd(OP_STRLEN, 40, 600, 8'h00), 1'b0, '0);
		put_str(16 * 5 + 12, 10, 1'b1);
		run_test("strlen_cross", mk_cmd(OP_STRLEN, 16 * 5 + 12, 600, 8'h00), 1'b0, '0);
		repeat (4) begin
			la = 16 + take_bits(8);
			put_str(la, take_bits(6) % MAX_LEN, 1'b1);
			run_test("strlen_rand", mk_cmd(OP_STRLEN, la, 600, 8'h00), 1'b0, '0);
		end
		repeat (4) begin
			la = 16 + take_bits(8);
			put_str(la, take_bits(6) % MAX_LEN, 1'b1);
			dl = rand_char();
			run_test("count_rand", mk_cmd(OP_COUNT, la, 600, dl), 1'b0, '0);
		end
		la = 16 + take_bits(8);
		lb = 512 + take_bits(8);
		len = take_bits(6) % MAX_LEN;
		put_str(la, len, 1'b1);
		copy_bytes(la, lb, len + 1);
		run_test("strcmp_equal", mk_cmd(OP_STRCMP, la, lb, 8'h00), 1'b0, '0);
		len = 2 + take_bits(5);
		put_str(la, len, 1'b1);
		copy_bytes(la, lb, len + 1);
		k = take_bits(5) % len;
		mirror[(lb + k) & (MEM_BYTES - 1)] = byte_at(lb + k) ^ 8'h20;
		run_test("strcmp_differ", mk_cmd(OP_STRCMP, la, lb, 8'h00), 1'b0, '0);
		put_str(lb, 20 + take_bits(4), 1'b1);
		len = take_bits(4);
		copy_bytes(lb, la, len);
		mirror[(la + len) & (MEM_BYTES - 1)] = 8'h00;
		run_test("strcmp_prefix", mk_cmd(OP_STRCMP, la, lb, 8'h00), 1'b0, '0);
		put_str(la, take_bits(6) % MAX_LEN, 1'b1);
		put_str(lb, take_bits(6) % MAX_LEN, 1'b1);
		run_test("strcmp_rand", mk_cmd(OP_STRCMP, la, lb, 8'h00), 1'b0, '0);
		put_str(la, MAX_LEN + 1, 1'b0);
		run_test("strlen_nonul", mk_cmd(OP_STRLEN, la, lb, 8'h00), 1'b0, '0);
		put_str(la, 20 + take_bits(4), 1'b1);
		c2 = mk_cmd(spu_op_e'(take_bits(1)), lb, la, rand_char());
		run_test("start_busy", mk_cmd(OP_STRLEN, la, lb, 8'h00), 1'b1, c2);
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
